/* hw/mr_cfg_if.sv */
/*
 * Decoded status fields shared by the I/O blocks
 *   regs  drives every field
 *   port  reads the connector enables
 *   crop  reads the video settings
 */
interface mr_cfg_if;

    // Connector enables
    logic       db15_en;
    logic       uart_en;

    // Video settings
    logic       crop_en;
    logic [3:0] vcopt;
    logic [1:0] crop_scale;
    logic [2:0] scan_fx;
    logic       force_scan2x;

    modport regs (
        output db15_en, uart_en, crop_en, vcopt, crop_scale, scan_fx, force_scan2x
    );

    modport port (
        input db15_en, uart_en
    );

    modport crop (
        input crop_en, vcopt, crop_scale, scan_fx, force_scan2x
    );

endinterface

/* hw/mr_crop_ctrl.sv */
/*
 * Vertical crop control
 *   permission from output size and video options
 *   signed offset from the crop option
 *   crop size once both permission and request hold
 */
`include "mr_io_cfg.svh"

module mr_crop_ctrl (
    input  logic                    clk_sys,
    input  logic                    rst,
    mr_cfg_if.crop                  cfg,
    input  logic [11:0]             hdmi_width,
    input  logic [11:0]             hdmi_height,
    input  logic                    direct_video,
    input  logic                    rotate_en,
    output logic                    crop_ok,
    output mr_io_pkg::crop_off_t    crop_off,
    output mr_io_pkg::crop_size_t   crop_size
);

    logic       size_ok;
    logic       video_ok;
    logic [4:0] off_x2;

    // Full HD output only
    assign size_ok = hdmi_width == 12'(`MR_HDMI_W) && hdmi_height == 12'(`MR_HDMI_H);

    // No scan lines, no forced doubler, plain scaling, no direct video or rotation
    assign video_ok = cfg.scan_fx == 3'd0 && !cfg.force_scan2x && cfg.crop_scale == 2'd0
                   && !direct_video && !rotate_en;

    // Two lines per option step
    assign off_x2 = {cfg.vcopt, 1'b0};

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            crop_ok   <= 1'b0;
            crop_off  <= '0;
            crop_size <= '0;
        end else begin
            crop_ok <= size_ok && video_ok;
            // Upper options wrap to negative offsets
            if (cfg.vcopt < 4'(`MR_VCOPT_WRAP)) begin
                crop_off <= mr_io_pkg::crop_off_t'(off_x2);
            end else begin
                crop_off <= mr_io_pkg::crop_off_t'(off_x2 - 5'(`MR_VCOPT_BIAS));
            end
            // Uses last cycle's permission, so one cycle behind crop_ok
            if (crop_ok && cfg.crop_en) begin
                crop_size <= 12'(`MR_CROP_LINES);
            end else begin
                crop_size <= '0;
            end
        end
    end

    a_size_legal: assert property (
        @(posedge clk_sys) disable iff (rst)
        crop_size == '0 || crop_size == 12'(`MR_CROP_LINES)
    ) else $error("crop_size %0d is not a legal crop", crop_size);

endmodule

/* hw/mr_io_cfg.svh */
/*
 * User-I/O front end constants
 *   status word bit positions and field ranges
 *   vertical crop limits and the HDMI size that allows it
 *   user-port pin count
 */
`ifndef MR_IO_CFG_SVH
`define MR_IO_CFG_SVH

// Status word fields
`define MR_ST_FX_LO      3
`define MR_ST_FX_HI      5
`define MR_ST_DB15       37
`define MR_ST_UART       38
`define MR_ST_CROP_EN    41
`define MR_ST_VCOPT_LO   42
`define MR_ST_VCOPT_HI   45
`define MR_ST_SCALE_LO   46
`define MR_ST_SCALE_HI   47
`define MR_ST_FORCE2X    63

// Only full HD output can be cropped
`define MR_HDMI_W        1920
`define MR_HDMI_H        1080

// Crop geometry
`define MR_CROP_LINES    216
`define MR_VCOPT_WRAP    6
`define MR_VCOPT_BIAS    24

// DB15 / UART connector
`define MR_USER_W        7

`endif

/* hw/mr_io_pkg.sv */
/*
 * Shared types of the user-I/O front end
 *   status word and host write halves
 *   handshake states and user-port modes
 *   user-port pins, mouse deltas, crop offset and size
 */
`include "mr_io_cfg.svh"

package mr_io_pkg;

    // Host visible status
    typedef logic [63:0] status_word_t;
    typedef logic [31:0] status_half_t;

    // Which half a host write lands in
    typedef enum logic {
        ST_LOW  = 1'b0,
        ST_HIGH = 1'b1
    } status_sel_e;

    // Four-phase write port
    typedef enum logic {
        HS_IDLE = 1'b0,
        HS_ACK  = 1'b1
    } hs_state_e;

    // User-port pin usage
    typedef enum logic [1:0] {
        UP_IDLE = 2'd0,
        UP_DB15 = 2'd1,
        UP_UART = 2'd2
    } port_mode_e;

    typedef logic [`MR_USER_W-1:0] user_port_t;

    // Mouse movement, sign taken from the flag byte
    typedef logic signed [8:0] mouse_delta_t;

    // Crop offset in lines, -16 to +15
    typedef logic signed [4:0] crop_off_t;
    typedef logic [11:0] crop_size_t;

endpackage

/* hw/mr_io_top.sv */
/*
 * User-I/O front end top level
 *   status registers steering the user port and crop blocks
 *   PS/2 mouse decoder
 */
module mr_io_top (
    input  logic                      clk_sys,
    input  logic                      rst,
    // Host status write
    input  logic                      st_req,
    input  mr_io_pkg::status_sel_e    st_sel,
    input  mr_io_pkg::status_half_t   st_data,
    output logic                      st_ack,
    output mr_io_pkg::status_word_t   status,
    // User port
    input  mr_io_pkg::user_port_t     user_in,
    input  mr_io_pkg::user_port_t     db15_out,
    input  logic                      game_tx,
    output mr_io_pkg::user_port_t     user_out,
    output logic                      game_rx,
    // Mouse
    input  logic [24:0]               ps2_mouse,
    output logic                      mouse_st,
    output mr_io_pkg::mouse_delta_t   mouse_dx,
    output mr_io_pkg::mouse_delta_t   mouse_dy,
    output logic [7:0]                mouse_f,
    // Vertical crop
    input  logic [11:0]               hdmi_width,
    input  logic [11:0]               hdmi_height,
    input  logic                      direct_video,
    input  logic                      rotate_en,
    output logic                      crop_ok,
    output mr_io_pkg::crop_off_t      crop_off,
    output mr_io_pkg::crop_size_t     crop_size
);

    mr_cfg_if u_cfg ();

    mr_status_regs u_regs (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .st_req       ( st_req       ),
        .st_sel       ( st_sel       ),
        .st_data      ( st_data      ),
        .st_ack       ( st_ack       ),
        .status       ( status       ),
        .cfg          ( u_cfg.regs   )
    );

    mr_userport u_port (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .cfg          ( u_cfg.port   ),
        .user_in      ( user_in      ),
        .db15_out     ( db15_out     ),
        .game_tx      ( game_tx      ),
        .user_out     ( user_out     ),
        .game_rx      ( game_rx      )
    );

    mr_mouse_decode u_mouse (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .ps2_mouse    ( ps2_mouse    ),
        .mouse_st     ( mouse_st     ),
        .mouse_dx     ( mouse_dx     ),
        .mouse_dy     ( mouse_dy     ),
        .mouse_f      ( mouse_f      )
    );

    mr_crop_ctrl u_crop (
        .clk_sys      ( clk_sys      ),
        .rst          ( rst          ),
        .cfg          ( u_cfg.crop   ),
        .hdmi_width   ( hdmi_width   ),
        .hdmi_height  ( hdmi_height  ),
        .direct_video ( direct_video ),
        .rotate_en    ( rotate_en    ),
        .crop_ok      ( crop_ok      ),
        .crop_off     ( crop_off     ),
        .crop_size    ( crop_size    )
    );

endmodule

/* hw/mr_mouse_decode.sv */
/*
 * PS/2 mouse packet decoder
 *   new packet flagged by a change of bit 24
 *   one-cycle strobe with 9-bit sign-extended deltas
 */
module mr_mouse_decode (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic [24:0]               ps2_mouse,
    output logic                      mouse_st,
    output mr_io_pkg::mouse_delta_t   mouse_dx,
    output mr_io_pkg::mouse_delta_t   mouse_dy,
    output logic [7:0]                mouse_f
);

    logic tog_l;
    logic new_pkt;

    assign new_pkt = ps2_mouse[24] ^ tog_l;

    // Toggle bit of the previous cycle
    always_ff @(posedge clk_sys) begin
        tog_l <= ps2_mouse[24];
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            mouse_st <= 1'b0;
        end else begin
            mouse_st <= new_pkt;
        end
    end

    // Flag bits 4 and 5 carry the X and Y signs
    always_ff @(posedge clk_sys) begin
        if (new_pkt) begin
            mouse_f  <= ps2_mouse[7:0];
            mouse_dx <= {ps2_mouse[4], ps2_mouse[15:8]};
            mouse_dy <= {ps2_mouse[5], ps2_mouse[23:16]};
        end
    end

    a_st_single: assert property (
        @(posedge clk_sys) disable iff (rst)
        mouse_st |=> !mouse_st
    ) else $error("mouse_st high on two consecutive cycles");

endmodule

/* hw/mr_status_regs.sv */
/*
 * Status register block
 *   four-phase req/ack host write port
 *   64-bit status word written in two 32-bit halves
 *   field decode onto the configuration interface
 */
`include "mr_io_cfg.svh"

module mr_status_regs (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic                      st_req,
    input  mr_io_pkg::status_sel_e    st_sel,
    input  mr_io_pkg::status_half_t   st_data,
    output logic                      st_ack,
    output mr_io_pkg::status_word_t   status,
    mr_cfg_if.regs                    cfg
);

    mr_io_pkg::hs_state_e hs_state;

    // Write port FSM
    // The half is stored on the edge that moves to HS_ACK
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            hs_state <= mr_io_pkg::HS_IDLE;
            status   <= '0;
        end else begin
            case (hs_state)
                mr_io_pkg::HS_IDLE: begin
                    if (st_req) begin
                        if (st_sel == mr_io_pkg::ST_HIGH) begin
                            status[63:32] <= st_data;
                        end else begin
                            status[31:0] <= st_data;
                        end
                        hs_state <= mr_io_pkg::HS_ACK;
                    end
                end
                mr_io_pkg::HS_ACK: begin
                    // Hold ack until the host lets go of req
                    if (!st_req) begin
                        hs_state <= mr_io_pkg::HS_IDLE;
                    end
                end
                default: begin
                    hs_state <= mr_io_pkg::HS_IDLE;
                end
            endcase
        end
    end

    assign st_ack = hs_state == mr_io_pkg::HS_ACK;

    // Connector enables
    assign cfg.db15_en = status[`MR_ST_DB15];
    assign cfg.uart_en = status[`MR_ST_UART];

    // Video options
    assign cfg.crop_en      = status[`MR_ST_CROP_EN];
    assign cfg.vcopt        = status[`MR_ST_VCOPT_HI:`MR_ST_VCOPT_LO];
    assign cfg.crop_scale   = status[`MR_ST_SCALE_HI:`MR_ST_SCALE_LO];
    assign cfg.scan_fx      = status[`MR_ST_FX_HI:`MR_ST_FX_LO];
    assign cfg.force_scan2x = status[`MR_ST_FORCE2X];

    // Ack only answers a request seen on the edge before
    a_ack_after_req: assert property (
        @(posedge clk_sys) disable iff (rst)
        $rose(st_ack) |-> $past(st_req)
    ) else $error("st_ack rose without st_req");

endmodule

/* hw/mr_userport.sv */
/*
 * User-port output mux and UART receive gate
 *   DB15 over UART over idle, registered on clk_sys
 *   receive line taken from pin 1 while the UART is on
 */
module mr_userport (
    input  logic                    clk_sys,
    input  logic                    rst,
    mr_cfg_if.port                  cfg,
    input  mr_io_pkg::user_port_t   user_in,
    input  mr_io_pkg::user_port_t   db15_out,
    input  logic                    game_tx,
    output mr_io_pkg::user_port_t   user_out,
    output logic                    game_rx
);

    mr_io_pkg::port_mode_e mode;

    // DB15 wins when both enables are set
    always_comb begin
        if (cfg.db15_en) begin
            mode = mr_io_pkg::UP_DB15;
        end else if (cfg.uart_en) begin
            mode = mr_io_pkg::UP_UART;
        end else begin
            mode = mr_io_pkg::UP_IDLE;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            user_out <= '1;
        end else begin
            case (mode)
                mr_io_pkg::UP_DB15: user_out <= db15_out;
                // Transmit on pin 0, other pins pulled high
                mr_io_pkg::UP_UART: user_out <= {{($bits(user_out) - 1){1'b1}}, game_tx};
                default:            user_out <= '1;
            endcase
        end
    end

    // Line idles high when the UART is off
    assign game_rx = cfg.uart_en ? user_in[1] : 1'b1;

endmodule

/* tb.f */
+incdir+hw
hw/mr_io_pkg.sv
hw/mr_cfg_if.sv
hw/mr_status_regs.sv
hw/mr_userport.sv
hw/mr_mouse_decode.sv
hw/mr_crop_ctrl.sv
hw/mr_io_top.sv
test/tb_mr_io.sv

/* test/tb_mr_io.sv */
/*
 * Testbench for the user-I/O front end
 *   clock, reset and watchdog
 *   four-phase status writes
 *   table of user-port, crop and mouse cases applied in a loop
 *   error counts and closing report
 */
`include "mr_io_cfg.svh"

module tb_mr_io;

    localparam logic [31:0] SEED     = 32'hdd85abac;
    localparam int          HS_LIMIT = 8;

    typedef struct {
        mr_io_pkg::status_word_t st;
        logic [11:0]             w;
        logic [11:0]             h;
        logic                    dv;
        logic                    rot;
        logic                    tx;
        mr_io_pkg::user_port_t   db;
        logic                    ui1;
        logic                    tog;
        mr_io_pkg::user_port_t   exp_uo;
        logic                    exp_rx;
        logic                    exp_ok;
        mr_io_pkg::crop_off_t    exp_off;
        mr_io_pkg::crop_size_t   exp_size;
    } row_t;

    logic                    clk_sys;
    logic                    rst;
    logic                    st_req;
    mr_io_pkg::status_sel_e  st_sel;
    mr_io_pkg::status_half_t st_data;
    logic                    st_ack;
    mr_io_pkg::status_word_t status;
    mr_io_pkg::user_port_t   user_in;
    mr_io_pkg::user_port_t   db15_out;
    logic                    game_tx;
    mr_io_pkg::user_port_t   user_out;
    logic                    game_rx;
    logic [24:0]             ps2_mouse;
    logic                    mouse_st;
    mr_io_pkg::mouse_delta_t mouse_dx;
    mr_io_pkg::mouse_delta_t mouse_dy;
    logic [7:0]              mouse_f;
    logic [11:0]             hdmi_width;
    logic [11:0]             hdmi_height;
    logic                    direct_video;
    logic                    rotate_en;
    logic                    crop_ok;
    mr_io_pkg::crop_off_t    crop_off;
    mr_io_pkg::crop_size_t   crop_size;

    row_t                    rows[$];
    row_t                    r;
    int                      mismatch_cnt;
    int                      fail_cnt;
    int                      pulse_cnt;
    int                      pulse_base;
    int                      exp_pulses;
    logic                    prev_tog;
    logic [31:0]             rnd;
    logic [7:0]              exp_f;
    int                      dx_val;
    int                      dy_val;
    mr_io_pkg::mouse_delta_t exp_dx;
    mr_io_pkg::mouse_delta_t exp_dy;

    mr_io_top u_dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // Strobes seen at the falling edge, where mouse_st is stable
    always @(negedge clk_sys) begin
        if (!rst && mouse_st === 1'b1) begin
            pulse_cnt++;
        end
    end

    initial begin
        @(negedge rst);
        repeat (rows.size() * 40 + 50) @(posedge clk_sys);
        $display("Watchdog expired, the run did not finish in time");
        $display("Mismatches: %0d, other errors: %0d", mismatch_cnt, fail_cnt + 1);
        $display("Result: FAILED");
        $finish;
    end

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] got);
        $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, what, exp, got);
        mismatch_cnt++;
    endtask

    // Columns: fx db15 uart crop vcopt scale f2x, width height dv rot, tx db ui1 tog,
    // then expected user_out game_rx crop_ok crop_off crop_size
    function automatic void add_row(int fx, int db15, int uart, int crop, int v, int scale,
                                    int f2x, int w, int h, int dv, int rot, int tx, int db,
                                    int ui1, int tog, int uo, int rx, int ok, int off,
                                    int size);
        row_t n;
        n.st = '0;
        n.st[`MR_ST_FX_HI:`MR_ST_FX_LO]       = fx[2:0];
        n.st[`MR_ST_DB15]                     = db15[0];
        n.st[`MR_ST_UART]                     = uart[0];
        n.st[`MR_ST_CROP_EN]                  = crop[0];
        n.st[`MR_ST_VCOPT_HI:`MR_ST_VCOPT_LO] = v[3:0];
        n.st[`MR_ST_SCALE_HI:`MR_ST_SCALE_LO] = scale[1:0];
        n.st[`MR_ST_FORCE2X]                  = f2x[0];
        n.w        = w[11:0];
        n.h        = h[11:0];
        n.dv       = dv[0];
        n.rot      = rot[0];
        n.tx       = tx[0];
        n.db       = db[6:0];
        n.ui1      = ui1[0];
        n.tog      = tog[0];
        n.exp_uo   = uo[6:0];
        n.exp_rx   = rx[0];
        n.exp_ok   = ok[0];
        n.exp_off  = mr_io_pkg::crop_off_t'(off);
        n.exp_size = mr_io_pkg::crop_size_t'(size);
        rows.push_back(n);
    endfunction

    task automatic write_half(input mr_io_pkg::status_sel_e sel,
                              input mr_io_pkg::status_half_t data);
        int n;
        if (st_ack !== 1'b0) begin
            $display("st_ack was still high when a new write started at %0t", $time);
            fail_cnt++;
        end
        st_sel  = sel;
        st_data = data;
        st_req  = 1'b1;
        n = 0;
        @(negedge clk_sys);
        while (st_ack !== 1'b1 && n < HS_LIMIT) begin
            @(negedge clk_sys);
            n++;
        end
        if (st_ack !== 1'b1) begin
            $display("Handshake timeout, st_ack never rose at %0t", $time);
            fail_cnt++;
        end
        st_req = 1'b0;
        n = 0;
        @(negedge clk_sys);
        while (st_ack !== 1'b0 && n < HS_LIMIT) begin
            @(negedge clk_sys);
            n++;
        end
        if (st_ack !== 1'b0) begin
            $display("Handshake timeout, st_ack never fell at %0t", $time);
            fail_cnt++;
        end
    endtask

    initial begin
        rnd = $urandom(SEED);
        mismatch_cnt = 0;
        fail_cnt     = 0;
        pulse_cnt    = 0;
        prev_tog     = 1'b0;
        rst          = 1'b1;
        st_req       = 1'b0;
        st_sel       = mr_io_pkg::ST_LOW;
        st_data      = '0;
        user_in      = '0;
        db15_out     = '0;
        game_tx      = 1'b0;
        ps2_mouse    = '0;
        hdmi_width   = '0;
        hdmi_height  = '0;
        direct_video = 1'b0;
        rotate_en    = 1'b0;

        add_row(0, 0, 0, 1,  0, 0, 0, 1920, 1080, 0, 0, 0, 'h55, 1, 1, 'h7f, 1, 1,   0, 216);
        add_row(0, 1, 1, 1,  3, 0, 0, 1920, 1080, 0, 0, 1, 'h2a, 0, 1, 'h2a, 0, 1,   6, 216);
        add_row(0, 0, 1, 0,  5, 0, 0, 1920, 1080, 0, 0, 0, 'h55, 1, 0, 'h7e, 1, 1,  10,   0);
        add_row(2, 0, 1, 1,  6, 0, 0, 1920, 1080, 0, 0, 1, 'h55, 0, 1, 'h7f, 0, 0, -12,   0);
        add_row(0, 0, 0, 1,  7, 0, 1, 1920, 1080, 0, 0, 1, 'h55, 0, 1, 'h7f, 1, 0, -10,   0);
        add_row(0, 1, 0, 1,  8, 1, 0, 1920, 1080, 0, 0, 0, 'h13, 0, 0, 'h13, 1, 0,  -8,   0);
        add_row(0, 0, 1, 1, 10, 0, 0, 1280,  720, 0, 0, 0, 'h55, 0, 0, 'h7e, 0, 0,  -4,   0);
        add_row(0, 1, 0, 1, 12, 0, 0, 1920, 1200, 0, 0, 1, 'h00, 1, 1, 'h00, 1, 0,   0,   0);
        add_row(0, 0, 0, 1, 15, 0, 0, 1920, 1080, 1, 0, 1, 'h55, 1, 0, 'h7f, 1, 0,   6,   0);
        add_row(0, 0, 1, 1,  9, 0, 0, 1920, 1080, 0, 1, 1, 'h55, 1, 0, 'h7f, 1, 0,  -6,   0);
        add_row(0, 1, 1, 1, 13, 0, 0, 1920, 1080, 0, 0, 0, 'h6c, 1, 1, 'h6c, 1, 1,   2, 216);
        add_row(0, 0, 1, 0,  1, 0, 0, 1920, 1080, 0, 0, 1, 'h55, 0, 1, 'h7f, 0, 1,   2,   0);
        add_row(7, 0, 0, 1, 11, 0, 0, 1920, 1080, 0, 0, 0, 'h55, 0, 0, 'h7f, 1, 0,  -2,   0);
        add_row(0, 0, 0, 1, 14, 0, 0, 1920, 1080, 0, 0, 0, 'h55, 0, 1, 'h7f, 1, 1,   4, 216);
        add_row(0, 0, 1, 1,  4, 3, 0, 1920, 1080, 0, 0, 0, 'h55, 1, 1, 'h7e, 1, 0,   8,   0);
        add_row(0, 0, 0, 1,  2, 0, 0, 1920, 1080, 0, 0, 0, 'h55, 0, 0, 'h7f, 1, 1,   4, 216);

        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;

        // Reset values
        if (st_ack !== 1'b0) report_mismatch("st_ack after reset", 0, st_ack);
        if (status !== '0) report_mismatch("status after reset", 0, status);
        if (user_out !== 7'h7f) report_mismatch("user_out after reset", 'h7f, user_out);
        if (mouse_st !== 1'b0) report_mismatch("mouse_st after reset", 0, mouse_st);
        if (crop_ok !== 1'b0) report_mismatch("crop_ok after reset", 0, crop_ok);
        if (crop_off !== '0) report_mismatch("crop_off after reset", 0, crop_off);
        if (crop_size !== '0) report_mismatch("crop_size after reset", 0, crop_size);

        foreach (rows[i]) begin
            r = rows[i];
            hdmi_width   = r.w;
            hdmi_height  = r.h;
            direct_video = r.dv;
            rotate_en    = r.rot;
            game_tx      = r.tx;
            db15_out     = r.db;
            rnd          = $urandom();
            user_in      = {rnd[6:2], r.ui1, rnd[0]};
            rnd          = $urandom();
            ps2_mouse    = {r.tog, rnd[23:0]};
            // A new packet only when the toggle bit moves
            if (r.tog != prev_tog) begin
                exp_pulses = 1;
                exp_f      = ps2_mouse[7:0];
                // Flag bit weighs -256 in the 9-bit delta
                dx_val     = int'(ps2_mouse[15:8]) - (ps2_mouse[4] ? 256 : 0);
                dy_val     = int'(ps2_mouse[23:16]) - (ps2_mouse[5] ? 256 : 0);
                exp_dx     = mr_io_pkg::mouse_delta_t'(dx_val);
                exp_dy     = mr_io_pkg::mouse_delta_t'(dy_val);
            end else begin
                exp_pulses = 0;
            end
            prev_tog   = r.tog;
            pulse_base = pulse_cnt;

            write_half(mr_io_pkg::ST_LOW, r.st[31:0]);
            write_half(mr_io_pkg::ST_HIGH, r.st[63:32]);
            repeat (4) @(negedge clk_sys);

            if (status !== r.st) report_mismatch($sformatf("row %0d status", i), r.st, status);
            if (user_out !== r.exp_uo)
                report_mismatch($sformatf("row %0d user_out", i), r.exp_uo, user_out);
            if (game_rx !== r.exp_rx)
                report_mismatch($sformatf("row %0d game_rx", i), r.exp_rx, game_rx);
            if (crop_ok !== r.exp_ok)
                report_mismatch($sformatf("row %0d crop_ok", i), r.exp_ok, crop_ok);
            if (crop_off !== r.exp_off)
                report_mismatch($sformatf("row %0d crop_off", i), r.exp_off, crop_off);
            if (crop_size !== r.exp_size)
                report_mismatch($sformatf("row %0d crop_size", i), r.exp_size, crop_size);
            if (pulse_cnt - pulse_base != exp_pulses)
                report_mismatch($sformatf("row %0d mouse_st pulses", i), exp_pulses,
                                pulse_cnt - pulse_base);
            if (mouse_f !== exp_f) report_mismatch($sformatf("row %0d mouse_f", i), exp_f, mouse_f);
            if (mouse_dx !== exp_dx)
                report_mismatch($sformatf("row %0d mouse_dx", i), exp_dx, mouse_dx);
            if (mouse_dy !== exp_dy)
                report_mismatch($sformatf("row %0d mouse_dy", i), exp_dy, mouse_dy);
        end

        $display("Mismatches: %0d, other errors: %0d", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
